// File: src/pool_geometry_pkg.sv
`default_nettype none

package pool_geometry_pkg;

    // Input map of one channel
    localparam int IFM_SIZE = 8;

    // Stride 2 halves each side
    localparam int OFM_SIZE = IFM_SIZE / 2;

    localparam int PIXEL_WIDTH = 8;

    localparam int IFM_ADDR_WIDTH = 6;   // 64 pixels
    localparam int OFM_ADDR_WIDTH = 4;   // 16 results

    // Two pixels are read per cycle
    localparam int PAIRS_PER_ROW = IFM_SIZE / 2;

    // Pool enable to result valid
    localparam int POOL_LATENCY = 2;

    // Layer sequencer states
    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,
        READ   = 2'b01,
        FINISH = 2'b10,
        HOLD   = 2'b11
    } pool_state_t;

endpackage

`default_nettype wire

// File: src/pool_bus_pkg.sv
`default_nettype none

package pool_bus_pkg;

    localparam int WB_ADDR_WIDTH = 8;
    localparam int WB_DATA_WIDTH = 8;

    // Word addresses
    localparam logic [WB_ADDR_WIDTH-1:0] IFM_BASE  = 8'h00;
    localparam logic [WB_ADDR_WIDTH-1:0] OFM_BASE  = 8'h40;
    localparam logic [WB_ADDR_WIDTH-1:0] CTRL_ADDR = 8'h50;

    // Control register bit for write start and read busy
    localparam int CTRL_START_BIT = 0;

    // Write release / read result ready
    localparam int CTRL_RELEASE_BIT = 1;

    typedef enum logic [1:0]
    {
        REGION_IFM,
        REGION_OFM,
        REGION_CTRL,
        REGION_NONE
    } wb_region_t;

endpackage

`default_nettype wire

// File: src/pool_control.sv
`timescale 1ns/1ns
`default_nettype none

module pool_control
(
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       start_pulse,
    input  logic                                       release_pulse,
    output logic                                       rd_en,
    output logic [pool_geometry_pkg::IFM_ADDR_WIDTH-1:0] rd_addr,
    output logic                                       fifo_shift,
    output logic                                       pool_en,
    output logic                                       ofm_wr_en,
    output logic [pool_geometry_pkg::OFM_ADDR_WIDTH-1:0] ofm_wr_addr,
    output logic                                       busy,
    output logic                                       result_ready
);

    import pool_geometry_pkg::*;

    pool_state_t state;
    pool_state_t state_next;

    logic                    last_pair;
    logic                    last_write;
    logic                    row_odd;
    logic [POOL_LATENCY-1:0] pool_dly;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE, FINISH:
            begin
                // Wait in HOLD while results are unreleased
                if (start_pulse)
                    state_next = result_ready ? HOLD : READ;
            end
            READ:
            begin
                if (last_pair)
                    state_next = FINISH;
            end
            HOLD:
            begin
                if (release_pulse)
                    state_next = READ;
            end
            default:
                state_next = IDLE;
        endcase
    end

    assign rd_en     = (state == READ);
    assign last_pair = (rd_addr == IFM_ADDR_WIDTH'(IFM_SIZE * IFM_SIZE - 2));

    // Pair address wraps to 0 after the last pair
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rd_addr <= '0;
        else if (rd_en)
            rd_addr <= rd_addr + IFM_ADDR_WIDTH'(2);
    end

    // Pixels arrive one cycle after the read
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            fifo_shift <= 1'b0;
            row_odd    <= 1'b0;
        end
        else
        begin
            fifo_shift <= rd_en;
            row_odd    <= rd_addr[$clog2(IFM_SIZE)];
        end
    end

    assign pool_en = fifo_shift & row_odd;   // Only odd rows close a block

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pool_dly <= '0;
        else
            pool_dly <= {pool_dly[POOL_LATENCY-2:0], pool_en};
    end

    assign ofm_wr_en  = pool_dly[POOL_LATENCY-1];
    assign last_write = ofm_wr_en && (ofm_wr_addr == OFM_ADDR_WIDTH'(OFM_SIZE * OFM_SIZE - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ofm_wr_addr <= '0;
        else if (ofm_wr_en)
            ofm_wr_addr <= ofm_wr_addr + 1'b1;
    end

    // Output memory occupancy set by the last write until the host releases it
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            result_ready <= 1'b0;
        else if (last_write)
            result_ready <= 1'b1;
        else if (release_pulse)
            result_ready <= 1'b0;
    end

    assign busy = (state == READ) || (state == HOLD) || fifo_shift || (|pool_dly);

endmodule

`default_nettype wire

// File: src/ifm_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module ifm_buffer
(
    input  logic                                       clk,
    input  logic                                       wr_en,
    input  logic [pool_geometry_pkg::IFM_ADDR_WIDTH-1:0] wr_addr,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0]    wr_data,
    input  logic                                       rd_en,
    input  logic [pool_geometry_pkg::IFM_ADDR_WIDTH-1:0] rd_addr,
    output logic [pool_geometry_pkg::PIXEL_WIDTH-1:0]    pix_a,
    output logic [pool_geometry_pkg::PIXEL_WIDTH-1:0]    pix_b
);

    import pool_geometry_pkg::*;

    logic [PIXEL_WIDTH-1:0]    mem [IFM_SIZE * IFM_SIZE];
    logic [IFM_ADDR_WIDTH-1:0] rd_addr_b;

    assign rd_addr_b = rd_addr + 1'b1;   // Right neighbour of an even address

    // Host write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            pix_a <= mem[rd_addr];
            pix_b <= mem[rd_addr_b];
        end
    end

endmodule

`default_nettype wire

// File: src/row_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module row_fifo
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    shift,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] in_a,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] in_b,
    output logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] out_a,
    output logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] out_b
);

    import pool_geometry_pkg::*;

    logic [PIXEL_WIDTH-1:0] line_a [PAIRS_PER_ROW];
    logic [PIXEL_WIDTH-1:0] line_b [PAIRS_PER_ROW];

    // One stage per pair in a row
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < PAIRS_PER_ROW; i++)
            begin
                line_a[i] <= '0;
                line_b[i] <= '0;
            end
        end
        else if (shift)
        begin
            line_a[0] <= in_a;
            line_b[0] <= in_b;
            for (int i = 1; i < PAIRS_PER_ROW; i++)
            begin
                line_a[i] <= line_a[i-1];
                line_b[i] <= line_b[i-1];
            end
        end
    end

    assign out_a = line_a[PAIRS_PER_ROW-1];
    assign out_b = line_b[PAIRS_PER_ROW-1];

endmodule

`default_nettype wire

// File: src/max_pool_unit.sv
`timescale 1ns/1ns
`default_nettype none

module max_pool_unit
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    pool_en,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] cur_a,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] cur_b,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] above_a,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] above_b,
    output logic [pool_geometry_pkg::PIXEL_WIDTH-1:0] result
);

    import pool_geometry_pkg::*;

    logic [PIXEL_WIDTH-1:0] col_max_a;
    logic [PIXEL_WIDTH-1:0] col_max_b;
    logic                   stage1_valid;

    // Vertical maxima in stage one
    always_ff @(posedge clk)
    begin
        if (pool_en)
        begin
            col_max_a <= (cur_a > above_a) ? cur_a : above_a;
            col_max_b <= (cur_b > above_b) ? cur_b : above_b;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            stage1_valid <= 1'b0;
        else
            stage1_valid <= pool_en;
    end

    // Horizontal maximum in stage two
    always_ff @(posedge clk)
    begin
        if (stage1_valid)
            result <= (col_max_a > col_max_b) ? col_max_a : col_max_b;
    end

endmodule

`default_nettype wire

// File: src/ofm_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module ofm_buffer
(
    input  logic                                       clk,
    input  logic                                       wr_en,
    input  logic [pool_geometry_pkg::OFM_ADDR_WIDTH-1:0] wr_addr,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0]    wr_data,
    input  logic [pool_geometry_pkg::OFM_ADDR_WIDTH-1:0] rd_addr,
    output logic [pool_geometry_pkg::PIXEL_WIDTH-1:0]    rd_data
);

    import pool_geometry_pkg::*;

    // Pooled map in row order
    logic [PIXEL_WIDTH-1:0] mem [OFM_SIZE * OFM_SIZE];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Registered on the bus side
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: src/wb_host_regs.sv
`timescale 1ns/1ns
`default_nettype none

module wb_host_regs
(
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       wb_cyc,
    input  logic                                       wb_stb,
    input  logic                                       wb_we,
    input  logic [pool_bus_pkg::WB_ADDR_WIDTH-1:0]       wb_adr,
    input  logic [pool_bus_pkg::WB_DATA_WIDTH-1:0]       wb_dat_w,
    input  logic [pool_bus_pkg::WB_DATA_WIDTH/8-1:0]     wb_sel,
    output logic [pool_bus_pkg::WB_DATA_WIDTH-1:0]       wb_dat_r,
    output logic                                       wb_ack,
    output logic                                       ifm_wr_en,
    output logic [pool_geometry_pkg::IFM_ADDR_WIDTH-1:0] ifm_wr_addr,
    output logic [pool_geometry_pkg::PIXEL_WIDTH-1:0]    ifm_wr_data,
    output logic [pool_geometry_pkg::OFM_ADDR_WIDTH-1:0] ofm_rd_addr,
    input  logic [pool_geometry_pkg::PIXEL_WIDTH-1:0]    ofm_rd_data,
    output logic                                       start_pulse,
    output logic                                       release_pulse,
    input  logic                                       busy,
    input  logic                                       result_ready
);

    import pool_geometry_pkg::*;
    import pool_bus_pkg::*;

    wb_region_t               region;
    logic [WB_ADDR_WIDTH-1:0] ifm_off;
    logic [WB_ADDR_WIDTH-1:0] ofm_off;
    logic [WB_DATA_WIDTH-1:0] status;
    logic                     access;
    logic                     wr_access;

    assign ifm_off = wb_adr - IFM_BASE;
    assign ofm_off = wb_adr - OFM_BASE;

    always_comb
    begin
        if (ifm_off < WB_ADDR_WIDTH'(IFM_SIZE * IFM_SIZE))
            region = REGION_IFM;
        else if (ofm_off < WB_ADDR_WIDTH'(OFM_SIZE * OFM_SIZE))
            region = REGION_OFM;
        else if (wb_adr == CTRL_ADDR)
            region = REGION_CTRL;
        else
            region = REGION_NONE;
    end

    // New cycle not yet acked
    assign access    = wb_cyc & wb_stb & ~wb_ack;
    assign wr_access = access & wb_we & wb_sel[0];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= access;
    end

    assign ifm_wr_en     = wr_access && (region == REGION_IFM);
    assign ifm_wr_addr   = ifm_off[IFM_ADDR_WIDTH-1:0];
    assign ifm_wr_data   = wb_dat_w;
    assign start_pulse   = wr_access && (region == REGION_CTRL) && wb_dat_w[CTRL_START_BIT];
    assign release_pulse = wr_access && (region == REGION_CTRL) && wb_dat_w[CTRL_RELEASE_BIT];

    assign ofm_rd_addr = ofm_off[OFM_ADDR_WIDTH-1:0];

    always_comb
    begin
        status                   = '0;
        status[CTRL_START_BIT]   = busy;
        status[CTRL_RELEASE_BIT] = result_ready;
    end

    // Input map and unmapped space read as zero
    always_ff @(posedge clk)
    begin
        if (access && !wb_we)
        begin
            case (region)
                REGION_OFM:  wb_dat_r <= ofm_rd_data;
                REGION_CTRL: wb_dat_r <= status;
                default:     wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/pool_layer_top.sv
`timescale 1ns/1ns
`default_nettype none

module pool_layer_top
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [pool_bus_pkg::WB_ADDR_WIDTH-1:0]   wb_adr,
    input  logic [pool_bus_pkg::WB_DATA_WIDTH-1:0]   wb_dat_w,
    input  logic [pool_bus_pkg::WB_DATA_WIDTH/8-1:0] wb_sel,
    output logic [pool_bus_pkg::WB_DATA_WIDTH-1:0]   wb_dat_r,
    output logic                                   wb_ack
);

    import pool_geometry_pkg::*;

    logic                      ifm_wr_en;
    logic [IFM_ADDR_WIDTH-1:0] ifm_wr_addr;
    logic [PIXEL_WIDTH-1:0]    ifm_wr_data;
    logic [OFM_ADDR_WIDTH-1:0] ofm_rd_addr;
    logic [PIXEL_WIDTH-1:0]    ofm_rd_data;
    logic                      start_pulse;
    logic                      release_pulse;
    logic                      busy;
    logic                      result_ready;
    logic                      rd_en;
    logic [IFM_ADDR_WIDTH-1:0] rd_addr;
    logic [PIXEL_WIDTH-1:0]    pix_a;
    logic [PIXEL_WIDTH-1:0]    pix_b;
    logic                      fifo_shift;
    logic [PIXEL_WIDTH-1:0]    above_a;
    logic [PIXEL_WIDTH-1:0]    above_b;
    logic                      pool_en;
    logic [PIXEL_WIDTH-1:0]    pool_result;
    logic                      ofm_wr_en;
    logic [OFM_ADDR_WIDTH-1:0] ofm_wr_addr;

    wb_host_regs u_host (.clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel,
        .wb_dat_r, .wb_ack, .ifm_wr_en, .ifm_wr_addr, .ifm_wr_data, .ofm_rd_addr, .ofm_rd_data,
        .start_pulse, .release_pulse, .busy, .result_ready);

    pool_control u_control (.clk, .reset, .start_pulse, .release_pulse, .rd_en, .rd_addr,
        .fifo_shift, .pool_en, .ofm_wr_en, .ofm_wr_addr, .busy, .result_ready);

    ifm_buffer u_ifm (.clk, .wr_en(ifm_wr_en), .wr_addr(ifm_wr_addr), .wr_data(ifm_wr_data),
        .rd_en, .rd_addr, .pix_a, .pix_b);

    // Pair from the row above
    row_fifo u_row_fifo (.clk, .reset, .shift(fifo_shift), .in_a(pix_a), .in_b(pix_b),
        .out_a(above_a), .out_b(above_b));

    max_pool_unit u_pool (.clk, .reset, .pool_en, .cur_a(pix_a), .cur_b(pix_b),
        .above_a, .above_b, .result(pool_result));

    ofm_buffer u_ofm (.clk, .wr_en(ofm_wr_en), .wr_addr(ofm_wr_addr), .wr_data(pool_result),
        .rd_addr(ofm_rd_addr), .rd_data(ofm_rd_data));

endmodule

`default_nettype wire

// File: sim/pool_layer_properties.sv
`timescale 1ns/1ns
`default_nettype none

module pool_layer_properties
(
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic ofm_wr_en,
    input logic result_ready,
    input logic release_pulse,
    input logic rd_en
);

    int read_len;
    int ack_fails = 0;
    int write_fails = 0;
    int ready_fails = 0;
    int read_fails = 0;
    int fail_count;

    assign fail_count = ack_fails + write_fails + ready_fails + read_fails;

    // Consecutive cycles in READ
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            read_len <= 0;
        else
            read_len <= rd_en ? read_len + 1 : 0;
    end

    ack_after_strobe: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb) && !$past(wb_ack))
    else
    begin
        $error("wb_ack without a strobe in the cycle before, or longer than one cycle");
        ack_fails++;
    end

    write_in_run: assert property (@(posedge clk) disable iff (reset)
        ofm_wr_en |-> !result_ready)
    else
    begin
        $error("Output memory written outside a run");
        write_fails++;
    end

    ready_held: assert property (@(posedge clk) disable iff (reset)
        $fell(result_ready) |-> $past(release_pulse))
    else
    begin
        $error("result_ready fell without a release");
        ready_fails++;
    end

    read_length: assert property (@(posedge clk) disable iff (reset) read_len <= 32)
    else
    begin
        $error("READ lasted more than 32 cycles");
        read_fails++;
    end

endmodule

bind pool_layer_top pool_layer_properties u_props (.clk, .reset, .wb_cyc, .wb_stb, .wb_ack,
    .ofm_wr_en, .result_ready, .release_pulse, .rd_en);

`default_nettype wire

// File: sim/tb_pool_layer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pool_layer;

    import pool_geometry_pkg::*;
    import pool_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;   // Tests take about 2900 cycles
    localparam int READY_POLLS    = 13;     // 36 cycles plus one poll

    logic                       clk;
    logic                       reset;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [WB_ADDR_WIDTH-1:0]   wb_adr;
    logic [WB_DATA_WIDTH-1:0]   wb_dat_w;
    logic [WB_DATA_WIDTH/8-1:0] wb_sel;
    logic [WB_DATA_WIDTH-1:0]   wb_dat_r;
    logic                       wb_ack;

    logic [PIXEL_WIDTH-1:0]   map [IFM_SIZE * IFM_SIZE];
    logic [PIXEL_WIDTH-1:0]   expected [OFM_SIZE * OFM_SIZE];
    logic [WB_DATA_WIDTH-1:0] rdata;
    int                       errors = 0;
    int                       cycles = 0;

    pool_layer_top i_dut (.clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel,
        .wb_dat_r, .wb_ack);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // One classic cycle with read data landing in rdata
    task automatic bus_access(input logic we, input logic [7:0] addr, input logic [7:0] wdata);
        int waits;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_dat_w <= wdata;
        waits = 0;
        @(negedge clk);
        @(negedge clk);
        while (!wb_ack && waits < 8)
        begin
            @(negedge clk);
            waits++;
        end
        assert (wb_ack && waits == 0)
        else
        begin
            errors++;
            $display("Bus cycle at address %h was not acked one cycle after the strobe", addr);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    function automatic logic [7:0] block_max(input int r, input int c);
        logic [7:0] m;
        int         base;
        base = 2 * r * IFM_SIZE + 2 * c;   // Top left corner of the block
        m = map[base];
        for (int i = 0; i < 2; i++)
            for (int j = 0; j < 2; j++)
                if (map[base + i * IFM_SIZE + j] > m)
                    m = map[base + i * IFM_SIZE + j];
        return m;
    endfunction

    task automatic compute_expected();
        for (int r = 0; r < OFM_SIZE; r++)
            for (int c = 0; c < OFM_SIZE; c++)
                expected[r * OFM_SIZE + c] = block_max(r, c);
    endtask

    task automatic load_map();
        for (int a = 0; a < IFM_SIZE * IFM_SIZE; a++)
            bus_access(1'b1, IFM_BASE + 8'(a), map[a]);
    endtask

    task automatic random_map();
        for (int a = 0; a < IFM_SIZE * IFM_SIZE; a++)
            map[a] = 8'($urandom);
    endtask

    // Small values with one large value at the same corner of every block
    task automatic corner_map(input int corner);
        int row;
        int col;
        for (int a = 0; a < IFM_SIZE * IFM_SIZE; a++)
        begin
            row = a / IFM_SIZE;
            col = a % IFM_SIZE;
            if ((row % 2) * 2 + (col % 2) == corner)
                map[a] = 8'(128 + $urandom % 128);
            else
                map[a] = 8'($urandom % 128);
        end
    endtask

    task automatic wait_ready();
        int polls;
        polls = 0;
        rdata = '0;
        while (!rdata[CTRL_RELEASE_BIT] && polls < 4 * READY_POLLS)
        begin
            bus_access(1'b0, CTRL_ADDR, 8'h00);
            polls++;
        end
        assert (polls <= READY_POLLS)
        else
        begin
            errors++;
            $display("result_ready did not rise within 36 cycles of the start");
        end
        check_value("wb_dat_r status when ready", 8'h02, rdata);
    endtask

    task automatic check_ofm();
        for (int i = 0; i < OFM_SIZE * OFM_SIZE; i++)
        begin
            bus_access(1'b0, OFM_BASE + 8'(i), 8'h00);
            check_value($sformatf("wb_dat_r at ofm %0d", i), expected[i], rdata);
        end
    endtask

    task automatic run_layer();
        load_map();
        compute_expected();
        bus_access(1'b1, CTRL_ADDR, 8'h01);   // Start
        bus_access(1'b0, CTRL_ADDR, 8'h00);
        check_value("wb_dat_r busy bit", 8'h01, rdata & 8'h01);
        wait_ready();
        check_ofm();
        bus_access(1'b1, CTRL_ADDR, 8'h02);   // Release
        bus_access(1'b0, CTRL_ADDR, 8'h00);
        check_value("wb_dat_r status after release", 8'h00, rdata);
    endtask

    initial
    begin
        void'($urandom(22));
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        bus_access(1'b0, CTRL_ADDR, 8'h00);
        check_value("wb_dat_r ctrl after reset", 8'h00, rdata);
        bus_access(1'b0, 8'h60, 8'h00);
        check_value("wb_dat_r unmapped", 8'h00, rdata);

        repeat (3)
        begin
            random_map();
            run_layer();
        end

        // Second start while the first results are still held
        random_map();
        load_map();
        compute_expected();
        bus_access(1'b1, CTRL_ADDR, 8'h01);
        wait_ready();
        random_map();
        load_map();
        bus_access(1'b1, CTRL_ADDR, 8'h01);
        bus_access(1'b0, CTRL_ADDR, 8'h00);
        check_value("wb_dat_r status in hold", 8'h03, rdata);
        check_ofm();
        bus_access(1'b0, CTRL_ADDR, 8'h00);
        check_value("wb_dat_r status still in hold", 8'h03, rdata);
        bus_access(1'b1, CTRL_ADDR, 8'h02);
        wait_ready();
        compute_expected();
        check_ofm();
        bus_access(1'b1, CTRL_ADDR, 8'h02);

        for (int a = 0; a < IFM_SIZE * IFM_SIZE; a++)
            map[a] = 8'h5a;   // All pixels equal
        run_layer();
        for (int k = 0; k < 4; k++)
        begin
            corner_map(k);
            run_layer();
        end

        $display("Closing report: %0d check errors, %0d assertion failures", errors,
            i_dut.u_props.fail_count);
        if (errors == 0 && i_dut.u_props.fail_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/pool_geometry_pkg.sv
src/pool_bus_pkg.sv
src/pool_control.sv
src/ifm_buffer.sv
src/row_fifo.sv
src/max_pool_unit.sv
src/ofm_buffer.sv
src/wb_host_regs.sv
src/pool_layer_top.sv
sim/pool_layer_properties.sv
sim/tb_pool_layer.sv

// File: Makefile
# Verilator build and run of the max-pooling layer testbench

VERILATOR ?= verilator
TOP       ?= tb_pool_layer
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
